// File: adc_usb_framer.f
hdl/adc_pkg.sv
hdl/frame_pkg.sv
hdl/adc_conditioner.sv
hdl/sample_buffer.sv
hdl/frame_writer.sv
hdl/adc_usb_framer.sv
testbench/tb_clock_gen.sv
testbench/adc_usb_framer_props.sv
testbench/tb_adc_usb_framer.sv

// File: hdl/adc_conditioner.sv
module adc_conditioner import adc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  adc_sample_t adc_data,
    input  logic        adc_valid,       // One-cycle strobe per conversion
    input  logic        adc_otr,         // Over range, qualified by adc_valid
    input  adc_sample_t adc_midpoint,    // Substitute for over-range samples
    output adc_sample_t decim_sample,
    output logic        decim_strobe
);

    adc_sample_t          tap0, tap1, tap2;           // Last three raw samples, newest first
    adc_sample_t          pair_hi, pair_lo, hi_clip;  // Sorting network terms
    adc_sample_t          med3;                       // Median of the taps
    adc_sample_t          push_val;                   // Value entering the window
    adc_sample_t          ring [ADC_DECIM_N];         // Averaging window
    logic [ADC_IDX_W-1:0] ring_idx;                   // Oldest entry, also decimation phase
    logic                 ring_wrap;                  // Last slot of the window
    logic [ADC_SUM_W-1:0] sum_q;                      // Sum of the window contents
    logic [ADC_SUM_W-1:0] sum_next;                   // Sum after this strobe's push
    logic [ADC_SUM_W-1:0] avg_full;                   // Rounded mean before narrowing

    // ====================
    // Median-of-3 prefilter
    // ====================
    assign pair_hi = (tap0 > tap1) ? tap0 : tap1;
    assign pair_lo = (tap0 > tap1) ? tap1 : tap0;
    assign hi_clip = (pair_hi < tap2) ? pair_hi : tap2;     // min(max(a,b), c)
    assign med3    = (pair_lo > hi_clip) ? pair_lo : hi_clip;

    assign push_val = adc_otr ? adc_midpoint : med3;        // OTR replaces the median

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tap0 <= ADC_RESET_SAMPLE;
            tap1 <= ADC_RESET_SAMPLE;
            tap2 <= ADC_RESET_SAMPLE;
        end else if (adc_valid) begin
            tap2 <= tap1;                                   // Shift after the median is used
            tap1 <= tap0;
            tap0 <= adc_data;
        end
    end

    // ====================
    // Moving-average decimator
    // ====================
    // Running sum swaps the oldest entry for the new one
    assign sum_next  = sum_q + ADC_SUM_W'(push_val) - ADC_SUM_W'(ring[ring_idx]);
    assign avg_full  = (sum_next + ADC_SUM_W'(ADC_ROUND)) / ADC_SUM_W'(ADC_DECIM_N);
    assign ring_wrap = (ring_idx == ADC_IDX_W'(ADC_DECIM_N - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_q        <= '0;
            ring_idx     <= '0;
            decim_strobe <= 1'b0;
            for (int i = 0; i < ADC_DECIM_N; i++) begin
                ring[i] <= '0;                              // Window starts empty
            end
        end else begin
            decim_strobe <= 1'b0;                           // Pulse by default off
            if (adc_valid) begin
                sum_q          <= sum_next;
                ring[ring_idx] <= push_val;
                if (ring_wrap) begin
                    ring_idx     <= '0;
                    decim_strobe <= 1'b1;                   // Every 30th strobe
                end else begin
                    ring_idx <= ring_idx + 1'b1;
                end
            end
        end
    end

    // Mean includes the value pushed on the same strobe
    always_ff @(posedge clk) begin
        if (adc_valid && ring_wrap) begin
            decim_sample <= adc_sample_t'(avg_full);
        end
    end

endmodule

// File: hdl/adc_pkg.sv
package adc_pkg;

    // ====================
    // Converter sample format
    // ====================
    localparam int ADC_W = 12;                              // Converter resolution

    typedef logic [ADC_W-1:0] adc_sample_t;                 // Raw or averaged sample word

    // ====================
    // Conditioning chain
    // ====================
    localparam int ADC_DECIM_N = 30;                        // Averaging window = decimation
    localparam int ADC_IDX_W   = $clog2(ADC_DECIM_N);       // Ring position width
    localparam int ADC_SUM_W   = 17;                        // Holds 30 full-scale samples
    localparam int ADC_ROUND   = ADC_DECIM_N / 2;           // Half-up rounding offset

    // Prefilter taps start at mid-scale so the first medians carry no step
    localparam adc_sample_t ADC_RESET_SAMPLE = adc_sample_t'(2048);

endpackage

// File: hdl/adc_usb_framer.sv
module adc_usb_framer import adc_pkg::*, frame_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  adc_sample_t adc_data,
    input  logic        adc_valid,
    input  logic        adc_otr,
    input  adc_sample_t adc_midpoint,
    input  logic        fifo_full,
    output frame_byte_t fifo_din,
    output logic        fifo_wr_en
);

    adc_sample_t decim_sample;           // Conditioner to buffer
    logic        decim_strobe;
    adc_sample_t buf_sample;             // Buffer to writer
    logic        buf_avail;
    logic        take;                   // Writer back to buffer

    // ====================
    // Producer, buffer, consumer
    // ====================
    adc_conditioner i_conditioner (
        .clk          (clk),
        .rst_n        (rst_n),
        .adc_data     (adc_data),
        .adc_valid    (adc_valid),
        .adc_otr      (adc_otr),
        .adc_midpoint (adc_midpoint),
        .decim_sample (decim_sample),
        .decim_strobe (decim_strobe)
    );

    sample_buffer i_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .decim_sample (decim_sample),
        .decim_strobe (decim_strobe),
        .take         (take),
        .buf_sample   (buf_sample),
        .buf_avail    (buf_avail)
    );

    frame_writer i_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .buf_sample (buf_sample),
        .buf_avail  (buf_avail),
        .fifo_full  (fifo_full),
        .take       (take),
        .fifo_din   (fifo_din),
        .fifo_wr_en (fifo_wr_en)
    );

endmodule

// File: hdl/frame_pkg.sv
package frame_pkg;

    // ====================
    // FIFO byte and markers
    // ====================
    typedef logic [7:0] frame_byte_t;                       // One USB FIFO byte

    localparam frame_byte_t FRAME_HEAD1 = 8'hAA;            // Frame start, first byte
    localparam frame_byte_t FRAME_HEAD2 = 8'h55;            // Frame start, second byte
    localparam frame_byte_t FRAME_TAIL1 = 8'h55;            // Frame end, first byte
    localparam frame_byte_t FRAME_TAIL2 = 8'hAA;            // Frame end, second byte

    // ====================
    // Frame geometry
    // ====================
    localparam int SAMPLES_PER_FRAME = 128;                 // Two bytes per sample
    localparam int FRAME_CNT_W       = $clog2(SAMPLES_PER_FRAME); // Wraps after last sample

    // Writer FSM, one state per byte kind plus idle
    typedef enum logic [2:0] {
        IDLE,       // Nothing to send
        HEAD1,      // AA
        HEAD2,      // 55
        BYTE_HI,    // Sample bits 11..4
        BYTE_LO,    // Zero nibble + bits 3..0
        TAIL1,      // 55
        TAIL2       // AA
    } frame_state_t;

endpackage

// File: hdl/frame_writer.sv
module frame_writer import adc_pkg::*, frame_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  adc_sample_t buf_sample,
    input  logic        buf_avail,
    input  logic        fifo_full,       // Back-pressure, hold state while high
    output logic        take,            // Low byte committed
    output frame_byte_t fifo_din,
    output logic        fifo_wr_en
);

    frame_state_t           state, state_next;
    logic [FRAME_CNT_W-1:0] sample_cnt;  // Samples already sent in this frame
    logic                   frame_last;  // Current sample closes the frame
    logic                   step;        // Current byte goes out this cycle
    frame_byte_t            byte_sel;

    assign step       = (state != IDLE) && !fifo_full;
    assign frame_last = (sample_cnt == FRAME_CNT_W'(SAMPLES_PER_FRAME - 1));
    assign take       = (state == BYTE_LO) && !fifo_full;

    // ====================
    // Next-state logic
    // ====================
    always_comb begin
        state_next = state;                                 // Stay by default
        case (state)
            IDLE: begin
                if (buf_avail) begin
                    state_next = (sample_cnt == '0) ? HEAD1 : BYTE_HI;
                end
            end
            HEAD1:   if (!fifo_full) state_next = HEAD2;
            HEAD2:   if (!fifo_full) state_next = BYTE_HI;  // Current is still held
            BYTE_HI: if (!fifo_full) state_next = BYTE_LO;
            BYTE_LO: begin
                if (!fifo_full) begin
                    state_next = frame_last ? TAIL1 : IDLE;
                end
            end
            TAIL1:   if (!fifo_full) state_next = TAIL2;
            TAIL2: begin
                if (!fifo_full) begin
                    state_next = buf_avail ? HEAD1 : IDLE;  // Back-to-back frames
                end
            end
            default: state_next = IDLE;
        endcase
    end

    // State register and frame position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            sample_cnt <= '0;
        end else begin
            state <= state_next;
            if (take) begin
                sample_cnt <= sample_cnt + 1'b1;            // Wraps to 0 after 128
            end
        end
    end

    // ====================
    // Byte selection and FIFO write
    // ====================
    always_comb begin
        case (state)
            HEAD1:   byte_sel = FRAME_HEAD1;
            HEAD2:   byte_sel = FRAME_HEAD2;
            BYTE_HI: byte_sel = buf_sample[11:4];
            BYTE_LO: byte_sel = {4'b0000, buf_sample[3:0]}; // Zero-padded low nibble
            TAIL1:   byte_sel = FRAME_TAIL1;
            TAIL2:   byte_sel = FRAME_TAIL2;
            default: byte_sel = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fifo_din   <= '0;
            fifo_wr_en <= 1'b0;
        end else begin
            fifo_din   <= byte_sel;
            fifo_wr_en <= step;                             // Never after a full cycle
        end
    end

endmodule

// File: hdl/sample_buffer.sv
module sample_buffer import adc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  adc_sample_t decim_sample,
    input  logic        decim_strobe,    // New average, never stalled
    input  logic        take,            // Writer consumed current
    output adc_sample_t buf_sample,
    output logic        buf_avail        // Current entry valid
);

    adc_sample_t pend_sample;            // Waiting entry
    logic        pend_valid;
    logic        load_cur;               // Move pending into current this cycle

    // Refill on consumption, or as soon as current has emptied
    assign load_cur = pend_valid && (take || !buf_avail);

    // ====================
    // Occupancy flags
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_avail  <= 1'b0;
            pend_valid <= 1'b0;
        end else begin
            if (load_cur) begin
                buf_avail <= 1'b1;
            end else if (take) begin
                buf_avail <= 1'b0;                          // Drained, nothing behind it
            end

            // A strobe in the same cycle as a refill keeps pending full
            if (decim_strobe) begin
                pend_valid <= 1'b1;
            end else if (load_cur) begin
                pend_valid <= 1'b0;
            end
        end
    end

    // Data path, newest strobe overwrites an unread pending sample
    always_ff @(posedge clk) begin
        if (decim_strobe) begin
            pend_sample <= decim_sample;
        end
        if (load_cur) begin
            buf_sample <= pend_sample;                      // Old pending value moves up
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the framer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_adc_usb_framer \
    -f adc_usb_framer.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1

// File: testbench/adc_usb_framer_props.sv
module adc_usb_framer_props import frame_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        fifo_full,
    input logic        fifo_wr_en,
    input frame_byte_t fifo_din
);

    // ====================
    // FIFO port rules
    // ====================
    // A full FIFO blocks the write that would follow it
    a_no_write_after_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        fifo_full |=> !fifo_wr_en
    ) else $error("fifo_wr_en high in the cycle after fifo_full");

    // Outputs idle while reset is applied
    a_quiet_in_reset: assert property (
        @(posedge clk)
        !rst_n |-> (!fifo_wr_en && (fifo_din == '0))
    ) else $error("FIFO outputs not idle during reset");

    a_din_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        fifo_wr_en |-> !$isunknown(fifo_din)
    ) else $error("fifo_din has X or Z bits while fifo_wr_en is high");

endmodule

// File: testbench/tb_adc_usb_framer.sv
module tb_adc_usb_framer import adc_pkg::*, frame_pkg::*; ();

    localparam int CYCLE_LIMIT = 40000;        // Two frames take about 15.5k and stalls get the rest
    localparam int FRAME_BYTES = 2 * SAMPLES_PER_FRAME + 4;  // Header, samples, trailer
    localparam adc_sample_t MIDPOINT = 12'd2048;

    logic        clk, rst_n;
    adc_sample_t adc_data, adc_midpoint;
    logic        adc_valid, adc_otr, fifo_full, fifo_wr_en;
    frame_byte_t fifo_din;

    logic [15:0] lfsr;                         // Stimulus generator state
    adc_sample_t ref_taps [3];                 // Model of the raw sample history
    int unsigned ref_sum;                      // Sum of the current block of 30
    int          ref_cnt, means_made, cycle_cnt;
    adc_sample_t exp_q [$];                    // Expected samples in write order
    int          frame_pos, frames_done;
    frame_byte_t hi_byte;
    logic        stall_en;                     // Random back-pressure on
    logic        full_prev;                    // fifo_full seen at the previous rising edge

    tb_clock_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    adc_usb_framer i_dut (
        .clk(clk), .rst_n(rst_n), .adc_data(adc_data), .adc_valid(adc_valid),
        .adc_otr(adc_otr), .adc_midpoint(adc_midpoint), .fifo_full(fifo_full),
        .fifo_din(fifo_din), .fifo_wr_en(fifo_wr_en)
    );

    bind adc_usb_framer adc_usb_framer_props i_props (
        .clk(clk), .rst_n(rst_n), .fifo_full(fifo_full),
        .fifo_wr_en(fifo_wr_en), .fifo_din(fifo_din)
    );

    // ====================
    // Helpers
    // ====================
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [11:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);                         // One step per bit
            bits = {bits[10:0], lfsr[0]};
        end
    endtask

    // Value a strobe adds to the window is the midpoint on over range or else the median
    function automatic adc_sample_t ref_push_value(input adc_sample_t a, input adc_sample_t b,
                                                   input adc_sample_t c, input logic otr);
        if (otr) begin
            return MIDPOINT;
        end else if ((a <= b && b <= c) || (c <= b && b <= a)) begin
            return b;
        end else if ((b <= a && a <= c) || (c <= a && a <= b)) begin
            return a;
        end
        return c;
    endfunction

    task automatic model_strobe(input adc_sample_t raw, input logic otr);
        ref_sum += ref_push_value(ref_taps[0], ref_taps[1], ref_taps[2], otr);
        ref_taps[2] = ref_taps[1];                          // History moves even on over range
        ref_taps[1] = ref_taps[0];
        ref_taps[0] = raw;
        ref_cnt++;
        if (ref_cnt == ADC_DECIM_N) begin
            exp_q.push_back(adc_sample_t'((ref_sum + ADC_DECIM_N / 2) / ADC_DECIM_N));
            means_made++;
            ref_sum = 0;                                    // Window is exactly one block
            ref_cnt = 0;
        end
    endtask

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_byte(input string what, input frame_byte_t got, input frame_byte_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("ERROR %s: got 0x%h expected 0x%h", what, got, exp));
        end
    endtask

    task automatic check_sample(input string what, input adc_sample_t got, input adc_sample_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("ERROR %s: got 0x%h expected 0x%h", what, got, exp));
        end
    endtask

    // ====================
    // Stimulus on the falling edge
    // ====================
    initial begin
        logic [11:0] bits;
        logic        strobe_now;
        int          strobe_cnt;
        adc_data     = '0;
        adc_valid    = 1'b0;
        adc_otr      = 1'b0;
        adc_midpoint = MIDPOINT;
        fifo_full    = 1'b0;
        lfsr         = 16'd6;                               // Seed
        ref_taps     = '{MIDPOINT, MIDPOINT, MIDPOINT};     // Taps come out of reset at mid-scale
        ref_sum      = 0;
        ref_cnt      = 0;
        means_made   = 0;
        stall_en     = 1'b0;
        strobe_now   = 1'b0;
        strobe_cnt   = 0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            strobe_now = !strobe_now;                       // Every second cycle
            if (strobe_now) begin
                draw_bits(12, bits);
                adc_data  = bits;
                adc_valid = 1'b1;
                adc_otr   = (strobe_cnt % 16 == 15);        // One in 16
                model_strobe(bits, adc_otr);
                strobe_cnt++;
            end else begin
                adc_valid = 1'b0;
                adc_otr   = 1'b0;
            end
            if (stall_en) begin
                draw_bits(1, bits);
                fifo_full = bits[0];
            end else begin
                fifo_full = 1'b0;
            end
        end
    end

    // ====================
    // Comparison and end of run
    // ====================
    initial begin
        frame_pos   = 0;
        frames_done = 0;
        cycle_cnt   = 0;
        full_prev   = 1'b0;
    end

    // Registered outputs are read at the rising edge before they update
    always @(posedge clk) begin
        if (rst_n && fifo_wr_en) begin
            if (means_made == 0) begin
                fail_stop("A byte was written before the first decimated sample existed");
            end
            if (full_prev) begin
                fail_stop("A byte was written in the cycle after fifo_full was high");
            end
            if (frame_pos == 0) begin
                check_byte("fifo_din header 1", fifo_din, 8'hAA);
            end else if (frame_pos == 1) begin
                check_byte("fifo_din header 2", fifo_din, 8'h55);
            end else if (frame_pos == FRAME_BYTES - 2) begin
                check_byte("fifo_din trailer 1", fifo_din, 8'h55);
            end else if (frame_pos == FRAME_BYTES - 1) begin
                check_byte("fifo_din trailer 2", fifo_din, 8'hAA);
            end else if (frame_pos % 2 == 0) begin
                hi_byte = fifo_din;                         // First half of a pair
            end else begin
                check_byte("fifo_din low byte top nibble", fifo_din & 8'hF0, 8'h00);
                if (exp_q.size() == 0) begin
                    fail_stop("A sample was written that the model never produced");
                end
                check_sample("fifo_din sample", {hi_byte, fifo_din[3:0]}, exp_q.pop_front());
            end
            if (frame_pos == FRAME_BYTES - 1) begin
                frame_pos = 0;
                frames_done++;
                stall_en  = 1'b1;                           // Second frame under back-pressure
            end else begin
                frame_pos++;
            end
        end
        full_prev = fifo_full;                              // Blocks the write one cycle later
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            fail_stop($sformatf("Timeout after %0d cycles with %0d frames done",
                                cycle_cnt, frames_done));
        end
    end

    initial begin
        wait (frames_done == 2);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;                                       // Held low from time zero
    end

    always #2 clk = ~clk;                                   // Period of 4

    // Release on a falling edge, clear of the DUT's sampling edge
    initial begin
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule
